// ==== hw/rs_settings.svh ====
`ifndef RS_SETTINGS_SVH
`define RS_SETTINGS_SVH

// Physical register file
`define NUM_PR 32
`define TAG_W 5

// Entries per functional unit class
`define NUM_LD 1
`define NUM_ST 1
`define NUM_BR 1
`define NUM_MULT 1
`define NUM_ALU 2

`define NUM_RS (`NUM_LD + `NUM_ST + `NUM_BR + `NUM_MULT + `NUM_ALU)
`define NUM_FU_CLASS 5

// Group layout LD, ST, BR, MULT, ALU from index 0 upward
`define RS_BASE_LD 0
`define RS_BASE_ST (`RS_BASE_LD + `NUM_LD)
`define RS_BASE_BR (`RS_BASE_ST + `NUM_ST)
`define RS_BASE_MULT (`RS_BASE_BR + `NUM_BR)
`define RS_BASE_ALU (`RS_BASE_MULT + `NUM_MULT)

`endif

// ==== hw/rs_pkg.sv ====
`include "rs_settings.svh"

package rs_pkg;

	// Functional unit class, also the index of the issue ports
	typedef enum logic [2:0] {
		FU_ALU  = 3'b000,
		FU_ST   = 3'b001,
		FU_LD   = 3'b010,
		FU_MULT = 3'b011,
		FU_BR   = 3'b100
	} fu_t;

	typedef enum logic [4:0] {
		ALU_ADDQ   = 5'h00,
		ALU_SUBQ   = 5'h01,
		ALU_AND    = 5'h02,
		ALU_BIC    = 5'h03,
		ALU_BIS    = 5'h04,
		ALU_ORNOT  = 5'h05,
		ALU_XOR    = 5'h06,
		ALU_EQV    = 5'h07,
		ALU_SRL    = 5'h08,
		ALU_SLL    = 5'h09,
		ALU_SRA    = 5'h0a,
		ALU_MULQ   = 5'h0b,
		ALU_CMPEQ  = 5'h0c,
		ALU_CMPLT  = 5'h0d,
		ALU_CMPLE  = 5'h0e,
		ALU_CMPULT = 5'h0f,
		ALU_CMPULE = 5'h10
	} alu_func_t;

	typedef logic [`TAG_W-1:0] tag_t;

	// Source operand, tag plus ready flag
	typedef struct packed {
		tag_t idx;
		logic ready;
	} operand_t;

	typedef struct packed {
		logic      busy;
		fu_t       fu;
		alu_func_t func;
		tag_t      dest;
		operand_t  t1;
		operand_t  t2;
	} rs_entry_t;

	//////////////////////////////
	// Group decode per class
	//////////////////////////////

	function automatic int fu_group_base(fu_t fu);
		case (fu)
			FU_LD:   return `RS_BASE_LD;
			FU_ST:   return `RS_BASE_ST;
			FU_BR:   return `RS_BASE_BR;
			FU_MULT: return `RS_BASE_MULT;
			default: return `RS_BASE_ALU;
		endcase
	endfunction

	// Unknown class codes get an empty group
	function automatic int fu_group_size(fu_t fu);
		case (fu)
			FU_LD:   return `NUM_LD;
			FU_ST:   return `NUM_ST;
			FU_BR:   return `NUM_BR;
			FU_MULT: return `NUM_MULT;
			FU_ALU:  return `NUM_ALU;
			default: return 0;
		endcase
	endfunction

endpackage

// ==== hw/rs_slot_if.sv ====
`include "rs_settings.svh"

// Per-slot status and control vectors, one bit per entry
interface rs_slot_if (
	input logic clock,
	input logic rst
);

	// From the slots
	logic [`NUM_RS-1:0] busy;
	logic [`NUM_RS-1:0] ready;

	// Load strobe from the allocator
	logic [`NUM_RS-1:0] write;

	// Free strobe from the issue selector
	logic [`NUM_RS-1:0] clear;

	modport slot (
		output busy,
		output ready,
		input  write,
		input  clear
	);

	modport alloc (
		input  clock,
		input  rst,
		input  busy,
		output write
	);

	modport select (
		input  clock,
		input  rst,
		input  ready,
		output clear
	);

endinterface

// ==== hw/rs_entry.sv ====
`include "rs_settings.svh"

module rs_entry #(
	parameter int IDX = 0
) (
	input  logic                 clock,
	input  logic                 rst,
	input  logic                 en,
	input  rs_pkg::fu_t          in_fu,
	input  rs_pkg::alu_func_t    in_func,
	input  rs_pkg::tag_t         in_dest,
	input  rs_pkg::operand_t     in_t1,
	input  rs_pkg::operand_t     in_t2,
	input  logic                 complete_en,
	input  rs_pkg::tag_t         cdb_tag,
	output rs_pkg::rs_entry_t    entry,
	rs_slot_if.slot              slot
);

	import rs_pkg::*;

	// Occupancy flag
	logic busy_q;

	// Stored instruction
	fu_t       fu_q;
	alu_func_t func_q;
	tag_t      dest_q;
	operand_t  t1_q;
	operand_t  t2_q;

	// Operand snoop on the common data bus
	function automatic operand_t wake(operand_t op);
		operand_t res;
		res = op;
		if (complete_en && (op.idx == cdb_tag))
			res.ready = 1'b1;
		return res;
	endfunction

	//////////////////////////////
	// Occupancy
	//////////////////////////////

	// Issue clear wins over a load
	always_ff @(posedge clock) begin
		if (rst) begin
			busy_q <= 1'b0;
		end else if (en) begin
			if (slot.clear[IDX])
				busy_q <= 1'b0;
			else if (slot.write[IDX])
				busy_q <= 1'b1;
		end
	end

	//////////////////////////////
	// Payload and wakeup
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (en) begin
			if (slot.write[IDX]) begin
				fu_q   <= in_fu;
				func_q <= in_func;
				dest_q <= in_dest;
				// Same-cycle broadcast forwards into the new entry
				t1_q   <= wake(in_t1);
				t2_q   <= wake(in_t2);
			end else if (busy_q) begin
				t1_q <= wake(t1_q);
				t2_q <= wake(t2_q);
			end
		end
	end

	assign entry = '{busy: busy_q, fu: fu_q, func: func_q, dest: dest_q, t1: t1_q, t2: t2_q};

	// Status back to allocator and selector
	assign slot.busy[IDX]  = busy_q;
	assign slot.ready[IDX] = busy_q && t1_q.ready && t2_q.ready;

	// Allocator must only target free slots
	a_no_write_busy: assert property (@(posedge clock) disable iff (rst)
		slot.write[IDX] |-> !busy_q);

endmodule

// ==== hw/rs_alloc.sv ====
`include "rs_settings.svh"

module rs_alloc (
	input  logic        dispatch_en,
	input  logic        en,
	input  rs_pkg::fu_t fu,
	output logic        hazard,
	rs_slot_if.alloc    alloc
);

	import rs_pkg::*;

	// Lowest free slot in the target group
	logic [`NUM_RS-1:0] free_sel;
	logic               free_found;

	//////////////////////////////
	// Free slot search
	//////////////////////////////

	always_comb begin
		int base;
		int size;
		base       = fu_group_base(fu);
		size       = fu_group_size(fu);
		free_sel   = '0;
		free_found = 1'b0;
		for (int i = 0; i < `NUM_RS; i++) begin
			if (!free_found && (i >= base) && (i < base + size) && !alloc.busy[i]) begin
				free_found  = 1'b1;
				free_sel[i] = 1'b1;
			end
		end
	end

	// Full group while dispatching
	assign hazard = dispatch_en && !free_found;

	// Load strobe held off during a stall
	assign alloc.write = (dispatch_en && en && free_found) ? free_sel : '0;

	// At most one slot loads per cycle
	a_write_onehot0: assert property (@(posedge alloc.clock) disable iff (alloc.rst)
		$onehot0(alloc.write));

endmodule

// ==== hw/rs_issue_select.sv ====
`include "rs_settings.svh"

module rs_issue_select (
	input  logic                                       en,
	input  logic [`NUM_FU_CLASS-1:0]                   fu_busy,
	input  rs_pkg::rs_entry_t [`NUM_RS-1:0]            entries,
	output logic [`NUM_FU_CLASS-1:0]                   issue_valid,
	output rs_pkg::tag_t [`NUM_FU_CLASS-1:0]           issue_dest,
	output rs_pkg::tag_t [`NUM_FU_CLASS-1:0]           issue_t1,
	output rs_pkg::tag_t [`NUM_FU_CLASS-1:0]           issue_t2,
	output rs_pkg::alu_func_t [`NUM_FU_CLASS-1:0]      issue_func,
	rs_slot_if.select                                  select
);

	import rs_pkg::*;

	//////////////////////////////
	// Per-class pick
	//////////////////////////////

	// Lowest ready index wins without age ordering
	always_comb begin
		int   base;
		int   size;
		logic found;
		select.clear = '0;
		issue_valid  = '0;
		issue_dest   = '0;
		issue_t1     = '0;
		issue_t2     = '0;
		for (int c = 0; c < `NUM_FU_CLASS; c++) begin
			base          = fu_group_base(fu_t'(c));
			size          = fu_group_size(fu_t'(c));
			found         = 1'b0;
			issue_func[c] = ALU_ADDQ;
			for (int i = 0; i < `NUM_RS; i++) begin
				if (!found && (i >= base) && (i < base + size) && select.ready[i]) begin
					found         = 1'b1;
					issue_dest[c] = entries[i].dest;
					issue_t1[c]   = entries[i].t1.idx;
					issue_t2[c]   = entries[i].t2.idx;
					issue_func[c] = entries[i].func;
					// Unit busy or stall holds the entry in place
					if (en && !fu_busy[c]) begin
						issue_valid[c]  = 1'b1;
						select.clear[i] = 1'b1;
					end
				end
			end
		end
	end

	// Only slots reporting ready may be freed
	a_clear_ready: assert property (@(posedge select.clock) disable iff (select.rst)
		(select.clear & ~select.ready) == '0);

endmodule

// ==== hw/rs.sv ====
`include "rs_settings.svh"

module rs (
	input  logic                                  clock,
	input  logic                                  rst,
	input  logic                                  en,
	input  logic                                  dispatch_en,
	input  rs_pkg::fu_t                           fu,
	input  rs_pkg::alu_func_t                     func,
	input  rs_pkg::tag_t                          dest,
	input  rs_pkg::tag_t                          t1_idx,
	input  logic                                  t1_ready,
	input  rs_pkg::tag_t                          t2_idx,
	input  logic                                  t2_ready,
	input  logic                                  complete_en,
	input  rs_pkg::tag_t                          cdb_tag,
	input  logic [`NUM_FU_CLASS-1:0]              fu_busy,
	output logic                                  hazard,
	output logic [`NUM_FU_CLASS-1:0]              issue_valid,
	output rs_pkg::tag_t [`NUM_FU_CLASS-1:0]      issue_dest,
	output rs_pkg::tag_t [`NUM_FU_CLASS-1:0]      issue_t1,
	output rs_pkg::tag_t [`NUM_FU_CLASS-1:0]      issue_t2,
	output rs_pkg::alu_func_t [`NUM_FU_CLASS-1:0] issue_func
);

	import rs_pkg::*;

	// Dispatch sources as operands
	operand_t t1_op;
	operand_t t2_op;

	// Registered state of every slot
	rs_entry_t [`NUM_RS-1:0] entries;

	assign t1_op = '{idx: t1_idx, ready: t1_ready};
	assign t2_op = '{idx: t2_idx, ready: t2_ready};

	rs_slot_if slots (
		.clock(clock),
		.rst(rst)
	);

	//////////////////////////////
	// Slots
	//////////////////////////////

	for (genvar g = 0; g < `NUM_RS; g++) begin : g_slot
		rs_entry #(
			.IDX(g)
		) u_entry (
			.clock(clock),
			.rst(rst),
			.en(en),
			.in_fu(fu),
			.in_func(func),
			.in_dest(dest),
			.in_t1(t1_op),
			.in_t2(t2_op),
			.complete_en(complete_en),
			.cdb_tag(cdb_tag),
			.entry(entries[g]),
			.slot(slots.slot)
		);
	end

	// Free slot pick and hazard
	rs_alloc u_alloc (
		.dispatch_en(dispatch_en),
		.en(en),
		.fu(fu),
		.hazard(hazard),
		.alloc(slots.alloc)
	);

	// Issue per class
	rs_issue_select u_select (
		.en(en),
		.fu_busy(fu_busy),
		.entries(entries),
		.issue_valid(issue_valid),
		.issue_dest(issue_dest),
		.issue_t1(issue_t1),
		.issue_t2(issue_t2),
		.issue_func(issue_func),
		.select(slots.select)
	);

endmodule

// ==== test/test_rs.sv ====
`include "rs_settings.svh"

module test_rs;

	timeunit 1ns;
	timeprecision 100ps;

	import rs_pkg::*;

	localparam int NC = `NUM_FU_CLASS;

	// One row per clock cycle
	typedef struct {
		string                 name;
		logic                  en;
		logic                  disp;
		fu_t                   fu;
		alu_func_t             func;
		tag_t                  dest;
		operand_t              t1;
		operand_t              t2;
		logic                  cmp;
		tag_t                  cdb;
		logic [NC-1:0]         busy;
		logic                  exp_haz;
		logic [NC-1:0]         exp_valid;
		tag_t [NC-1:0]         exp_dest;
		tag_t [NC-1:0]         exp_t1;
		tag_t [NC-1:0]         exp_t2;
		alu_func_t [NC-1:0]    exp_func;
	} row_t;

	logic                  clock;
	logic                  rst;
	logic                  en;
	logic                  dispatch_en;
	logic                  t1_ready;
	logic                  t2_ready;
	logic                  complete_en;
	logic                  hazard;
	fu_t                   fu;
	alu_func_t             func;
	tag_t                  dest;
	tag_t                  t1_idx;
	tag_t                  t2_idx;
	tag_t                  cdb_tag;
	logic [NC-1:0]         fu_busy;
	logic [NC-1:0]         issue_valid;
	tag_t [NC-1:0]         issue_dest;
	tag_t [NC-1:0]         issue_t1;
	tag_t [NC-1:0]         issue_t2;
	alu_func_t [NC-1:0]    issue_func;

	row_t rows [64];
	int   n_rows = 0;
	int   seed = 87;
	int   cycles = 0;

	rs DUT (.*);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// Run limit from reset length and table size
	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= 16 + n_rows + 20) begin
			$display("Test failures found");
			$fatal(1, "Timeout, the run did not finish within %0d cycles", cycles);
		end
	end

	//////////////////////////////
	// Row building
	//////////////////////////////

	function automatic operand_t ready_op();
		return '{idx: tag_t'($random(seed)), ready: 1'b1};
	endfunction

	function automatic operand_t waiting_op(tag_t t);
		return '{idx: t, ready: 1'b0};
	endfunction

	function automatic logic [NC-1:0] busy_mask(fu_t c);
		return (NC'(1) << int'(c));
	endfunction

	// Idle row without dispatch or bus
	task automatic add_row(input string name, input logic en_v, input logic [NC-1:0] busy_v,
		input logic haz);
		rows[n_rows].name      = name;
		rows[n_rows].en        = en_v;
		rows[n_rows].disp      = 1'b0;
		rows[n_rows].fu        = FU_ALU;
		rows[n_rows].func      = ALU_ADDQ;
		rows[n_rows].dest      = '0;
		rows[n_rows].t1        = '0;
		rows[n_rows].t2        = '0;
		rows[n_rows].cmp       = 1'b0;
		rows[n_rows].cdb       = '0;
		rows[n_rows].busy      = busy_v;
		rows[n_rows].exp_haz   = haz;
		rows[n_rows].exp_valid = '0;
		n_rows++;
	endtask

	task automatic set_disp(input fu_t c, input alu_func_t f, input tag_t d, input operand_t a,
		input operand_t b);
		rows[n_rows-1].disp = 1'b1;
		rows[n_rows-1].fu   = c;
		rows[n_rows-1].func = f;
		rows[n_rows-1].dest = d;
		rows[n_rows-1].t1   = a;
		rows[n_rows-1].t2   = b;
	endtask

	task automatic set_cdb(input tag_t t);
		rows[n_rows-1].cmp = 1'b1;
		rows[n_rows-1].cdb = t;
	endtask

	task automatic expect_issue(input fu_t c, input tag_t d, input alu_func_t f, input tag_t s1,
		input tag_t s2);
		int k;
		k = int'(c);
		rows[n_rows-1].exp_valid[k] = 1'b1;
		rows[n_rows-1].exp_dest[k]  = d;
		rows[n_rows-1].exp_t1[k]    = s1;
		rows[n_rows-1].exp_t2[k]    = s2;
		rows[n_rows-1].exp_func[k]  = f;
	endtask

	task automatic build_table();
		// Sources of dispatches still waiting to issue
		operand_t a1;
		operand_t b1;
		operand_t a2;
		operand_t b2;
		add_row("reset", 1'b1, '0, 1'b0);
		// Both sources ready so issue one cycle on
		a1 = ready_op();
		b1 = ready_op();
		add_row("alu_dispatch", 1'b1, '0, 1'b0);
		set_disp(FU_ALU, ALU_ADDQ, 5'd10, a1, b1);
		add_row("alu_issue", 1'b1, '0, 1'b0);
		expect_issue(FU_ALU, 5'd10, ALU_ADDQ, a1.idx, b1.idx);
		add_row("alu_idle", 1'b1, '0, 1'b0);
		// Wait on tag 4
		a1 = waiting_op(5'd4);
		b1 = ready_op();
		add_row("wait_dispatch", 1'b1, '0, 1'b0);
		set_disp(FU_ALU, ALU_SUBQ, 5'd11, a1, b1);
		add_row("wait_hold", 1'b1, '0, 1'b0);
		add_row("wait_cdb", 1'b1, '0, 1'b0);
		set_cdb(5'd4);
		add_row("wake_issue", 1'b1, '0, 1'b0);
		expect_issue(FU_ALU, 5'd11, ALU_SUBQ, 5'd4, b1.idx);
		// Broadcast in the dispatch cycle
		a1 = waiting_op(5'd7);
		b1 = ready_op();
		add_row("fwd_dispatch", 1'b1, '0, 1'b0);
		set_disp(FU_LD, ALU_AND, 5'd12, a1, b1);
		set_cdb(5'd7);
		add_row("fwd_issue", 1'b1, '0, 1'b0);
		expect_issue(FU_LD, 5'd12, ALU_AND, 5'd7, b1.idx);
		// MULT unit busy with a one-entry group
		a1 = ready_op();
		b1 = ready_op();
		add_row("mult_dispatch", 1'b1, busy_mask(FU_MULT), 1'b0);
		set_disp(FU_MULT, ALU_MULQ, 5'd13, a1, b1);
		add_row("mult_hold", 1'b1, busy_mask(FU_MULT), 1'b0);
		add_row("mult_full", 1'b1, busy_mask(FU_MULT), 1'b1);
		set_disp(FU_MULT, ALU_XOR, 5'd14, ready_op(), ready_op());
		add_row("mult_release", 1'b1, '0, 1'b0);
		expect_issue(FU_MULT, 5'd13, ALU_MULQ, a1.idx, b1.idx);
		add_row("mult_dropped", 1'b1, '0, 1'b0);
		// Two ALU slots with lowest index first
		a1 = ready_op();
		b1 = ready_op();
		a2 = ready_op();
		b2 = ready_op();
		add_row("alu_first", 1'b1, busy_mask(FU_ALU), 1'b0);
		set_disp(FU_ALU, ALU_BIS, 5'd15, a1, b1);
		add_row("alu_second", 1'b1, busy_mask(FU_ALU), 1'b0);
		set_disp(FU_ALU, ALU_XOR, 5'd16, a2, b2);
		add_row("alu_full", 1'b1, '0, 1'b1);
		set_disp(FU_ALU, ALU_SRL, 5'd17, ready_op(), ready_op());
		expect_issue(FU_ALU, 5'd15, ALU_BIS, a1.idx, b1.idx);
		add_row("alu_next", 1'b1, '0, 1'b0);
		expect_issue(FU_ALU, 5'd16, ALU_XOR, a2.idx, b2.idx);
		add_row("alu_empty", 1'b1, '0, 1'b0);
		// Separate classes issue together
		a1 = ready_op();
		b1 = ready_op();
		a2 = ready_op();
		b2 = ready_op();
		add_row("st_dispatch", 1'b1, busy_mask(FU_ST), 1'b0);
		set_disp(FU_ST, ALU_BIC, 5'd18, a1, b1);
		add_row("br_dispatch", 1'b1, busy_mask(FU_ST), 1'b0);
		set_disp(FU_BR, ALU_CMPEQ, 5'd19, a2, b2);
		add_row("st_br_issue", 1'b1, '0, 1'b0);
		expect_issue(FU_ST, 5'd18, ALU_BIC, a1.idx, b1.idx);
		expect_issue(FU_BR, 5'd19, ALU_CMPEQ, a2.idx, b2.idx);
		// Stall freezes issue and dispatch
		a1 = ready_op();
		b1 = ready_op();
		add_row("stall_prep", 1'b1, '0, 1'b0);
		set_disp(FU_ALU, ALU_EQV, 5'd20, a1, b1);
		add_row("stall_dispatch", 1'b0, '0, 1'b0);
		set_disp(FU_LD, ALU_SRL, 5'd21, ready_op(), ready_op());
		add_row("stall_hold", 1'b0, '0, 1'b0);
		add_row("resume", 1'b1, '0, 1'b0);
		expect_issue(FU_ALU, 5'd20, ALU_EQV, a1.idx, b1.idx);
		add_row("resume_idle", 1'b1, '0, 1'b0);
	endtask

	//////////////////////////////
	// Compare tasks
	//////////////////////////////

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
			$display("Test failures found");
			$fatal(1, "Stopping at first mismatch");
		end
	endtask

	task automatic check_tag(input string name, input tag_t exp, input tag_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected %0d, actual %0d", name, exp, act);
			$display("Test failures found");
			$fatal(1, "Stopping at first mismatch");
		end
	endtask

	task automatic check_func(input string name, input alu_func_t exp, input alu_func_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected %s (%0d), actual %s (%0d)", name, exp.name(), exp,
				act.name(), act);
			$display("Test failures found");
			$fatal(1, "Stopping at first mismatch");
		end
	endtask

	//////////////////////////////
	// Drive and check
	//////////////////////////////

	task automatic apply_row(input int i);
		en          = rows[i].en;
		dispatch_en = rows[i].disp;
		fu          = rows[i].fu;
		func        = rows[i].func;
		dest        = rows[i].dest;
		t1_idx      = rows[i].t1.idx;
		t1_ready    = rows[i].t1.ready;
		t2_idx      = rows[i].t2.idx;
		t2_ready    = rows[i].t2.ready;
		complete_en = rows[i].cmp;
		cdb_tag     = rows[i].cdb;
		fu_busy     = rows[i].busy;
	endtask

	// Payload fields only matter on a valid issue
	task automatic check_row(input int i);
		fu_t   cls;
		string pre;
		check_bit({rows[i].name, " hazard"}, rows[i].exp_haz, hazard);
		for (int c = 0; c < NC; c++) begin
			cls = fu_t'(c);
			pre = $sformatf("%s %s", rows[i].name, cls.name());
			check_bit({pre, " issue_valid"}, rows[i].exp_valid[c], issue_valid[c]);
			if (rows[i].exp_valid[c]) begin
				check_tag({pre, " issue_dest"}, rows[i].exp_dest[c], issue_dest[c]);
				check_tag({pre, " issue_t1"}, rows[i].exp_t1[c], issue_t1[c]);
				check_tag({pre, " issue_t2"}, rows[i].exp_t2[c], issue_t2[c]);
				check_func({pre, " issue_func"}, rows[i].exp_func[c], issue_func[c]);
			end
		end
	endtask

	initial begin
		rst = 1'b1;
		build_table();
		// Idle inputs through reset
		apply_row(0);
		repeat (16) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;
		for (int i = 0; i < n_rows; i++) begin
			apply_row(i);
			#5;
			check_row(i);
			@(negedge clock);
		end
		$display("All tests passed!");
		$finish;
	end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/rs_pkg.sv
hw/rs_slot_if.sv
hw/rs_entry.sv
hw/rs_alloc.sv
hw/rs_issue_select.sv
hw/rs.sv
test/test_rs.sv
